// ==== logic/ccu_pkg.sv ====
package ccu_pkg;

    // Memory side widths
    localparam int CCU_ADDR_WIDTH = 32;
    localparam int CCU_WORD_WIDTH = 32;
    localparam int CCU_LINE_SIZE  = 16;
    localparam int CCU_LINE_WIDTH = CCU_LINE_SIZE * 8;

    // A line moves over the bus as this many word beats
    localparam int CCU_BEATS      = CCU_LINE_WIDTH / CCU_WORD_WIDTH;
    localparam int CCU_BEAT_WIDTH = $clog2(CCU_BEATS);

    // Requestor 0 is the fill path, requestor 1 the victim writeback path
    localparam int CCU_NUM_REQ    = 2;
    localparam int CCU_IDX_WIDTH  = $clog2(CCU_NUM_REQ);

    // Line transaction from a requestor, address is line aligned
    typedef struct packed {
        logic                      we;
        logic [CCU_ADDR_WIDTH-1:0] addr;
        logic [CCU_LINE_WIDTH-1:0] data;
    } ccu_req_t;

    // One word beat on the external memory bus
    typedef struct packed {
        logic                      we;
        logic [CCU_ADDR_WIDTH-1:0] addr;
        logic [CCU_WORD_WIDTH-1:0] data;
    } ccu_bus_req_t;

    typedef enum logic [1:0] {
        ARB_IDLE = 2'b00,
        ARB_BUSY = 2'b01,
        ARB_DONE = 2'b10
    } ccu_arb_state_t;

    // GAP keeps the bus enable low for one cycle between beats
    typedef enum logic [1:0] {
        BIU_IDLE = 2'b00,
        BIU_BEAT = 2'b01,
        BIU_GAP  = 2'b10,
        BIU_DONE = 2'b11
    } ccu_biu_state_t;

endpackage

// ==== logic/ccu_arb.sv ====
`timescale 1ns/1ps

module ccu_arb (
    input  logic                                          clk,
    input  logic                                          i_rst,

    // Requestor side, bit 0 has the highest priority
    input  logic [ccu_pkg::CCU_NUM_REQ-1:0]               i_req_valid,
    input  ccu_pkg::ccu_req_t [ccu_pkg::CCU_NUM_REQ-1:0]  i_req,
    output logic [ccu_pkg::CCU_NUM_REQ-1:0]               o_req_done,
    output logic [ccu_pkg::CCU_LINE_WIDTH-1:0]            o_rsp_data,

    // BIU side
    input  logic                                          i_biu_done,
    input  logic [ccu_pkg::CCU_LINE_WIDTH-1:0]            i_biu_data,
    output logic                                          o_biu_en,
    output ccu_pkg::ccu_req_t                             o_biu_req
);

    import ccu_pkg::*;

    ccu_arb_state_t           state_r;
    ccu_arb_state_t           state_next;
    logic [CCU_IDX_WIDTH-1:0] pick_idx;
    logic                     any_valid;
    logic [CCU_IDX_WIDTH-1:0] idx_r;
    logic                     arb_done;
    logic                     biu_en;
    logic [CCU_NUM_REQ-1:0]   done_sel;

    // Fixed priority pick, the lowest numbered valid requestor wins
    always_comb begin
        pick_idx  = '0;
        any_valid = 1'b0;
        for (int i = CCU_NUM_REQ - 1; i >= 0; i--) begin
            if (i_req_valid[i]) begin
                pick_idx  = CCU_IDX_WIDTH'(i);
                any_valid = 1'b1;
            end
        end
    end

    // The index only follows the pick while idle and is held for the whole transaction
    always_ff @(posedge clk) begin
        if (i_rst) begin
            idx_r <= '0;
        end else if (state_r == ARB_IDLE) begin
            idx_r <= pick_idx;
        end
    end

    // FSM
    // A valid seen in IDLE starts a transaction, the BIU done ends it,
    // and DONE gives the requestor its one cycle done pulse
    always_comb begin
        case (state_r)
            ARB_IDLE: begin
                arb_done   = 1'b0;
                biu_en     = 1'b0;
                state_next = any_valid ? ARB_BUSY : ARB_IDLE;
            end
            ARB_BUSY: begin
                arb_done   = i_biu_done;
                biu_en     = i_req_valid[idx_r];
                state_next = i_biu_done ? ARB_DONE : ARB_BUSY;
            end
            ARB_DONE: begin
                arb_done   = 1'b0;
                biu_en     = 1'b0;
                state_next = ARB_IDLE;
            end
            default: begin
                arb_done   = 1'b0;
                biu_en     = 1'b0;
                state_next = ARB_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            state_r <= ARB_IDLE;
        end else begin
            state_r <= state_next;
        end
    end

    // Only the selected requestor sees done
    always_comb begin
        done_sel        = '0;
        done_sel[idx_r] = arb_done;
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_req_done <= '0;
        end else begin
            o_req_done <= done_sel;
        end
    end

    // The line lines up with the done pulse one cycle after the BIU done
    always_ff @(posedge clk) begin
        o_rsp_data <= i_biu_data;
    end

    // Enable to the BIU follows the selected valid while busy
    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_biu_en <= 1'b0;
        end else begin
            o_biu_en <= biu_en;
        end
    end

    always_ff @(posedge clk) begin
        o_biu_req <= i_req[idx_r];
    end

endmodule

// ==== logic/ccu_biu.sv ====
`timescale 1ns/1ps

module ccu_biu (
    input  logic                               clk,
    input  logic                               i_rst,

    // Line transaction from the arbiter
    input  logic                               i_biu_en,
    input  ccu_pkg::ccu_req_t                  i_biu_req,
    output logic                               o_biu_done,
    output logic [ccu_pkg::CCU_LINE_WIDTH-1:0] o_biu_data,

    // External memory bus, one word per beat
    output logic                               o_bus_en,
    output ccu_pkg::ccu_bus_req_t              o_bus_req,
    input  logic                               i_bus_ack,
    input  logic [ccu_pkg::CCU_WORD_WIDTH-1:0] i_bus_data
);

    import ccu_pkg::*;

    ccu_biu_state_t            state_r;
    ccu_biu_state_t            state_next;
    logic                      en_q;
    logic                      en_rise;
    logic [CCU_BEAT_WIDTH-1:0] beat_r;
    logic                      last_beat;
    logic                      beat_ack;
    logic [CCU_ADDR_WIDTH-1:0] beat_offset;
    ccu_req_t                  req_r;

    // The arbiter enable stays high for one cycle past done, so only a rising
    // edge may start a new line
    always_ff @(posedge clk) begin
        if (i_rst) begin
            en_q <= 1'b0;
        end else begin
            en_q <= i_biu_en;
        end
    end

    assign en_rise   = i_biu_en && !en_q;
    assign beat_ack  = (state_r == BIU_BEAT) && i_bus_ack;
    assign last_beat = (beat_r == CCU_BEAT_WIDTH'(CCU_BEATS - 1));

    // FSM
    // Each beat is followed by a one cycle GAP, the last beat goes to DONE
    always_comb begin
        case (state_r)
            BIU_IDLE: begin
                state_next = en_rise ? BIU_BEAT : BIU_IDLE;
            end
            BIU_BEAT: begin
                if (i_bus_ack) begin
                    state_next = last_beat ? BIU_DONE : BIU_GAP;
                end else begin
                    state_next = BIU_BEAT;
                end
            end
            BIU_GAP: begin
                state_next = BIU_BEAT;
            end
            BIU_DONE: begin
                state_next = BIU_IDLE;
            end
            default: begin
                state_next = BIU_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            state_r <= BIU_IDLE;
        end else begin
            state_r <= state_next;
        end
    end

    // Beat counter wraps back to zero after the fourth ack
    always_ff @(posedge clk) begin
        if (i_rst) begin
            beat_r <= '0;
        end else if (beat_ack) begin
            beat_r <= beat_r + 1'b1;
        end
    end

    // Latch the line request at the start, then fill read words in place
    // so the same register holds the response line for reads and writes
    always_ff @(posedge clk) begin
        if ((state_r == BIU_IDLE) && en_rise) begin
            req_r <= i_biu_req;
        end else if (beat_ack && !req_r.we) begin
            req_r.data[beat_r*CCU_WORD_WIDTH +: CCU_WORD_WIDTH] <= i_bus_data;
        end
    end

    // Word k sits at the line base plus 4k
    assign beat_offset = CCU_ADDR_WIDTH'({beat_r, 2'b00});

    // Built from held registers, so the beat is stable until its ack
    always_comb begin
        o_bus_req.we   = req_r.we;
        o_bus_req.addr = req_r.addr + beat_offset;
        o_bus_req.data = req_r.data[beat_r*CCU_WORD_WIDTH +: CCU_WORD_WIDTH];
    end

    assign o_bus_en   = (state_r == BIU_BEAT);
    assign o_biu_done = (state_r == BIU_DONE);
    assign o_biu_data = req_r.data;

endmodule

// ==== logic/ccu_top.sv ====
`timescale 1ns/1ps

module ccu_top (
    input  logic                                          clk,
    input  logic                                          i_rst,

    // Cache side requestors
    input  logic [ccu_pkg::CCU_NUM_REQ-1:0]               i_req_valid,
    input  ccu_pkg::ccu_req_t [ccu_pkg::CCU_NUM_REQ-1:0]  i_req,
    output logic [ccu_pkg::CCU_NUM_REQ-1:0]               o_req_done,
    output logic [ccu_pkg::CCU_LINE_WIDTH-1:0]            o_rsp_data,

    // External memory bus
    output logic                                          o_bus_en,
    output ccu_pkg::ccu_bus_req_t                         o_bus_req,
    input  logic                                          i_bus_ack,
    input  logic [ccu_pkg::CCU_WORD_WIDTH-1:0]            i_bus_data
);

    import ccu_pkg::*;

    // Arbiter to BIU
    logic                      biu_en;
    ccu_req_t                  biu_req;
    logic                      biu_done;
    logic [CCU_LINE_WIDTH-1:0] biu_data;

    ccu_arb u_arb (
        .clk         (clk),
        .i_rst       (i_rst),
        .i_req_valid (i_req_valid),
        .i_req       (i_req),
        .o_req_done  (o_req_done),
        .o_rsp_data  (o_rsp_data),
        .i_biu_done  (biu_done),
        .i_biu_data  (biu_data),
        .o_biu_en    (biu_en),
        .o_biu_req   (biu_req)
    );

    // Splits each line into word beats on the memory bus
    ccu_biu u_biu (
        .clk        (clk),
        .i_rst      (i_rst),
        .i_biu_en   (biu_en),
        .i_biu_req  (biu_req),
        .o_biu_done (biu_done),
        .o_biu_data (biu_data),
        .o_bus_en   (o_bus_en),
        .o_bus_req  (o_bus_req),
        .i_bus_ack  (i_bus_ack),
        .i_bus_data (i_bus_data)
    );

endmodule

// ==== tests/ccu_sva.sv ====
`timescale 1ns/1ps

module ccu_sva (
    input  logic                                 clk,
    input  logic                                 i_rst,
    input  logic [ccu_pkg::CCU_NUM_REQ-1:0]      i_req_valid,
    input  logic [ccu_pkg::CCU_NUM_REQ-1:0]      i_req_done,
    input  logic                                 i_bus_en,
    input  ccu_pkg::ccu_bus_req_t                i_bus_req,
    input  logic                                 i_bus_ack,
    input  ccu_pkg::ccu_arb_state_t              i_arb_state,
    input  logic [ccu_pkg::CCU_IDX_WIDTH-1:0]    i_arb_idx
);

    import ccu_pkg::*;

    int fail_count = 0;

    // Outputs are quiet in the first cycle out of reset
    reset_quiet: assert property (@(posedge clk)
        $fell(i_rst) |-> (!i_bus_en && (i_req_done == '0)))
        else begin
            fail_count++;
            $error("Bus enable or done high right after reset");
        end

    bus_req_stable: assert property (@(posedge clk) disable iff (i_rst)
        (i_bus_en && !i_bus_ack) |=> $stable(i_bus_req))
        else begin
            fail_count++;
            $error("Bus request changed while waiting for ack");
        end

    // Every beat is followed by the GAP or the end of the line
    gap_after_ack: assert property (@(posedge clk) disable iff (i_rst)
        (i_bus_en && i_bus_ack) |=> !i_bus_en)
        else begin
            fail_count++;
            $error("Bus enable stayed high after an ack");
        end

    valid_held: assert property (@(posedge clk) disable iff (i_rst)
        (i_arb_state != ARB_IDLE) |-> i_req_valid[i_arb_idx])
        else begin
            fail_count++;
            $error("Selected requestor dropped valid before its done");
        end

endmodule

bind ccu_top ccu_sva sva0 (
    .clk         (clk),
    .i_rst       (i_rst),
    .i_req_valid (i_req_valid),
    .i_req_done  (o_req_done),
    .i_bus_en    (o_bus_en),
    .i_bus_req   (o_bus_req),
    .i_bus_ack   (i_bus_ack),
    .i_arb_state (u_arb.state_r),
    .i_arb_idx   (u_arb.idx_r)
);

// ==== tests/ccu_tb.sv ====
`timescale 1ns/1ps

module ccu_tb;

    import ccu_pkg::*;

    localparam int NUM_TXN        = 150;
    localparam int NUM_LINES      = 8;
    localparam int TIMEOUT_CYCLES = 2 * NUM_TXN * 40;
    localparam logic [CCU_WORD_WIDTH-1:0] FILL_XOR = 32'hA5A50000;

    logic                              clk;
    logic                              rst;
    logic [CCU_NUM_REQ-1:0]            req_valid;
    ccu_req_t [CCU_NUM_REQ-1:0]        req;
    logic [CCU_NUM_REQ-1:0]            req_done;
    logic [CCU_LINE_WIDTH-1:0]         rsp_data;
    logic                              bus_en;
    ccu_bus_req_t                      bus_req;
    logic                              bus_ack;
    logic [CCU_WORD_WIDTH-1:0]         bus_data;

    logic [15:0]                       lfsr_state;
    logic [CCU_WORD_WIDTH-1:0]         mem [NUM_LINES*CCU_BEATS];
    logic [CCU_LINE_WIDTH-1:0]         model [NUM_LINES];
    ccu_bus_req_t                      beats [$];
    int                                issued [CCU_NUM_REQ];
    int                                finished [CCU_NUM_REQ];
    int                                idle_left [CCU_NUM_REQ];
    logic [CCU_NUM_REQ-1:0]            done_seen;
    logic                              unit_busy;
    int                                winner;
    logic                              slave_busy;
    int                                wait_left;
    logic                              ack_seen;
    logic                              en_seen;
    int                                cycles;

    ccu_top dut0 (
        .clk         (clk),
        .i_rst       (rst),
        .i_req_valid (req_valid),
        .i_req       (req),
        .o_req_done  (req_done),
        .o_rsp_data  (rsp_data),
        .o_bus_en    (bus_en),
        .o_bus_req   (bus_req),
        .i_bus_ack   (bus_ack),
        .i_bus_data  (bus_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Taps 16, 14, 13 and 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] draw_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic int word_index(input logic [CCU_ADDR_WIDTH-1:0] addr);
        return int'(addr[6:2]);
    endfunction

    task automatic check_equal(input logic [CCU_LINE_WIDTH-1:0] got,
                               input logic [CCU_LINE_WIDTH-1:0] exp, input string what);
        if (got !== exp) begin
            $display("FAIL at %0t: %s (got %0h, expected %0h)", $time, what, got, exp);
            $display("Simulation failed");
            $fatal(1, "Mismatch found");
        end
    endtask

    // Beats, response and slave memory of a finished line against the model
    task automatic check_line(input int r);
        int line;
        line = int'(req[r].addr[6:4]);
        check_equal(beats.size(), CCU_BEATS, "beat count per line");
        for (int k = 0; k < CCU_BEATS; k++) begin
            check_equal(beats[k].addr, req[r].addr + 4 * k, "beat address");
            check_equal(beats[k].we, req[r].we, "beat direction");
            if (req[r].we) begin
                check_equal(beats[k].data, req[r].data[k*CCU_WORD_WIDTH +: CCU_WORD_WIDTH],
                            "write beat data");
            end
        end
        if (req[r].we) begin
            model[line] = req[r].data;
        end
        check_equal(rsp_data, model[line], "response line");
        for (int k = 0; k < CCU_BEATS; k++) begin
            check_equal(mem[line*CCU_BEATS+k], model[line][k*CCU_WORD_WIDTH +: CCU_WORD_WIDTH],
                        "slave memory word");
        end
        beats.delete();
    endtask

    // Runs mid cycle, when outputs and driven inputs are settled
    task automatic observe_cycle();
        en_seen   = bus_en;
        ack_seen  = bus_ack;
        done_seen = req_done;
        if (bus_en && bus_ack) begin
            beats.push_back(bus_req);
            if (bus_req.we) begin
                mem[word_index(bus_req.addr)] = bus_req.data;
            end
        end
        // An idle unit serves requestor 0 whenever it is valid
        if (!unit_busy && (req_valid != '0)) begin
            unit_busy = 1'b1;
            winner    = req_valid[0] ? 0 : 1;
        end
        if (req_done != '0) begin
            check_equal(unit_busy, 1'b1, "done with no transaction in flight");
            check_equal(req_done, 1 << winner, "done bits do not match the winner");
            check_equal(req_valid[winner], 1'b1, "done while valid is low");
            check_line(winner);
            unit_busy = 1'b0;
        end
    endtask

    task automatic start_request(input int r);
        req[r].we   = (r == 1);
        req[r].addr = CCU_ADDR_WIDTH'({draw_bits(3), 4'b0000});
        req[r].data = '0;
        if (r == 1) begin
            for (int k = 0; k < CCU_BEATS; k++) begin
                req[r].data[k*CCU_WORD_WIDTH +: CCU_WORD_WIDTH] = draw_bits(CCU_WORD_WIDTH);
            end
        end
        req_valid[r] = 1'b1;
        issued[r]++;
    endtask

    // Runs just after the edge and acts on what the last cycle showed
    task automatic drive_cycle();
        for (int r = 0; r < CCU_NUM_REQ; r++) begin
            if (done_seen[r]) begin
                req_valid[r] = 1'b0;
                finished[r]++;
                idle_left[r] = draw_bits(2);
            end else if (!req_valid[r] && (issued[r] < NUM_TXN)) begin
                if (idle_left[r] == 0) begin
                    start_request(r);
                end else begin
                    idle_left[r]--;
                end
            end
        end
        // The slave holds ack for one cycle after 0 to 3 wait cycles
        if (ack_seen) begin
            bus_ack    = 1'b0;
            slave_busy = 1'b0;
        end else if (en_seen) begin
            if (!slave_busy) begin
                slave_busy = 1'b1;
                wait_left  = draw_bits(2);
            end
            if (wait_left == 0) begin
                bus_ack  = 1'b1;
                bus_data = mem[word_index(bus_req.addr)];
            end else begin
                wait_left--;
            end
        end
    endtask

    initial begin
        lfsr_state = 16'd22327;
        rst        = 1'b1;
        req_valid  = '0;
        req        = '0;
        bus_ack    = 1'b0;
        bus_data   = '0;
        done_seen  = '0;
        unit_busy  = 1'b0;
        winner     = 0;
        slave_busy = 1'b0;
        wait_left  = 0;
        ack_seen   = 1'b0;
        en_seen    = 1'b0;
        cycles     = 0;
        for (int r = 0; r < CCU_NUM_REQ; r++) begin
            issued[r]    = 0;
            finished[r]  = 0;
            idle_left[r] = 0;
        end
        // Every word starts as its own byte address XOR a fixed pattern
        for (int l = 0; l < NUM_LINES; l++) begin
            for (int k = 0; k < CCU_BEATS; k++) begin
                mem[l*CCU_BEATS+k] = CCU_WORD_WIDTH'(l * CCU_LINE_SIZE + k * 4) ^ FILL_XOR;
                model[l][k*CCU_WORD_WIDTH +: CCU_WORD_WIDTH] = mem[l*CCU_BEATS+k];
            end
        end

        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;

        while ((finished[0] < NUM_TXN) || (finished[1] < NUM_TXN)) begin
            @(negedge clk);
            observe_cycle();
            check_equal(dut0.sva0.fail_count, 0, "concurrent assertion failure count");
            cycles++;
            if (cycles >= TIMEOUT_CYCLES) begin
                $display("Run hung, transactions still open after %0d cycles", cycles);
                $display("Simulation failed");
                $fatal(1, "Timeout");
            end
            @(posedge clk);
            #1;
            drive_cycle();
        end

        repeat (2) @(posedge clk);
        if (dut0.sva0.fail_count != 0) begin
            $display("Concurrent assertions failed %0d times", dut0.sva0.fail_count);
            $display("Simulation failed");
            $fatal(1, "Assertion failures");
        end else begin
            $display("Simulation passed");
            $finish;
        end
    end

endmodule

// ==== filelist.f ====
logic/ccu_pkg.sv
logic/ccu_arb.sv
logic/ccu_biu.sv
logic/ccu_top.sv
tests/ccu_sva.sv
tests/ccu_tb.sv

// ==== Bender.yml ====
package:
  name: ccu

sources:
  - logic/ccu_pkg.sv
  - logic/ccu_arb.sv
  - logic/ccu_biu.sv
  - logic/ccu_top.sv
  - target: test
    files:
      - tests/ccu_sva.sv
      - tests/ccu_tb.sv
